/* Bender.yml */
package:
  name: output_queue

sources:
  - include_dirs:
      - hw
    files:
      - hw/oq_pkg.sv
      - hw/free_list_manager.sv
      - hw/packet_buffer.sv
      - hw/pifo_calendar.sv
      - hw/output_queue.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/oq_checker.sv
      - verification/oq_tb.sv

/* build.f */
+incdir+hw
hw/oq_pkg.sv
hw/free_list_manager.sv
hw/packet_buffer.sv
hw/pifo_calendar.sv
hw/output_queue.sv
verification/oq_checker.sv
verification/oq_tb.sv

/* hw/free_list_manager.sv */
`timescale 1ns/1ps
`default_nettype none

`include "oq_cfg.svh"

module free_list_manager
    import oq_pkg::*;
(
    input  wire             axis_aclk,
    input  wire             axis_resetn,
    input  wire             alloc_en,
    input  wire             free_en,
    input  wire buf_addr_t  free_addr,
    output buf_addr_t       alloc_addr,
    output buf_addr_t       next_addr,
    output buf_count_t      free_count,
    output logic            almost_full
);

    localparam int DEPTH = `OQ_BUF_DEPTH;
    localparam int SLACK = `OQ_ALMOST_FULL_SLACK;

    // link of every word, shared by the free list and the stored packets
    buf_addr_t  next_table [DEPTH];
    buf_addr_t  head;
    buf_addr_t  tail;
    buf_count_t count;

    //////////////////////////////////////////////////
    // free list update
    //////////////////////////////////////////////////

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            // chain all words in address order
            for (int i = 0; i < DEPTH; i++)
                next_table[i] <= buf_addr_t'(i + 1);
            head  <= '0;
            tail  <= buf_addr_t'(DEPTH - 1);
            count <= buf_count_t'(DEPTH);
        end
        else
        begin
            // freed word is appended behind the tail
            if (free_en)
            begin
                next_table[tail] <= free_addr;
                tail             <= free_addr;
            end

            if (alloc_en)
            begin
                // last free word taken while another one comes back
                if (free_en && count == buf_count_t'(1))
                    head <= free_addr;
                else
                    head <= next_table[head];
            end
            else if (free_en && count == '0)
            begin
                head <= free_addr;
            end

            case ({alloc_en, free_en})
                2'b10:   count <= count - buf_count_t'(1);
                2'b01:   count <= count + buf_count_t'(1);
                default: count <= count;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////

    assign alloc_addr  = head;
    // link of the word being read, used as the next read address
    assign next_addr   = next_table[free_addr];
    assign free_count  = count;
    assign almost_full = (count <= buf_count_t'(SLACK));

    // an allocation with nothing free would hand out a stored word
    assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        alloc_en |-> (count != '0))
        else $error("free list allocation with no free word");

endmodule

`default_nettype wire

/* hw/oq_cfg.svh */
`ifndef OQ_CFG_SVH
`define OQ_CFG_SVH

// one buffer word
`define OQ_DATA_WIDTH 32
`define OQ_KEEP_WIDTH 4

// shared word buffer
`define OQ_BUF_DEPTH 64
`define OQ_BUF_ADDR_WIDTH 6

// pifo calendar
`define OQ_CAL_DEPTH 8
`define OQ_RANK_WIDTH 8

// almost full when free words drop to this level
`define OQ_ALMOST_FULL_SLACK 8

`endif

/* hw/oq_pkg.sv */
`default_nettype none

`include "oq_cfg.svh"

package oq_pkg;

    // word address in the shared buffer
    typedef logic [`OQ_BUF_ADDR_WIDTH-1:0] buf_addr_t;

    // 0 .. OQ_BUF_DEPTH, so one bit wider than an address
    typedef logic [`OQ_BUF_ADDR_WIDTH:0] buf_count_t;

    // lower rank leaves first
    typedef logic [`OQ_RANK_WIDTH-1:0] rank_t;

    typedef struct packed {
        logic [`OQ_DATA_WIDTH-1:0] data;
        logic [`OQ_KEEP_WIDTH-1:0] keep;
        logic                      last;
    } word_t;

    // one stored packet in the calendar
    typedef struct packed {
        rank_t     rank;
        buf_addr_t addr;
    } cal_entry_t;

endpackage

`default_nettype wire

/* hw/output_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "oq_cfg.svh"

module output_queue
    import oq_pkg::*;
(
    input  wire                         axis_aclk,
    input  wire                         axis_resetn,
    input  wire [`OQ_DATA_WIDTH-1:0]    s_axis_tdata,
    input  wire [`OQ_KEEP_WIDTH-1:0]    s_axis_tkeep,
    input  wire                         s_axis_tlast,
    input  wire rank_t                  s_axis_rank,
    input  wire                         s_buffer_wr_en,
    input  wire                         s_pifo_insert_en,
    input  wire                         m_axis_tready,
    output logic                        m_axis_tvalid,
    output logic [`OQ_DATA_WIDTH-1:0]   m_axis_tdata,
    output logic [`OQ_KEEP_WIDTH-1:0]   m_axis_tkeep,
    output logic                        m_axis_tlast,
    output rank_t                       m_axis_rank,
    output logic                        buffer_almost_full,
    output logic                        pifo_full,
    output buf_count_t                  buffer_free_count
);

    typedef enum logic [1:0] {IDLE, FETCH, PRESENT} state_t;

    // enqueue stage
    word_t      in_word_d;
    rank_t      rank_d;
    logic       wr_en_d;
    logic       insert_en_d;
    logic       first_word;
    buf_addr_t  sop_addr;
    buf_addr_t  start_addr;
    cal_entry_t insert_entry;

    // submodule outputs
    buf_addr_t  alloc_addr;
    buf_addr_t  next_addr;
    word_t      rd_word;
    cal_entry_t top_entry;
    logic       cal_empty;

    // dequeue side
    state_t     state;
    logic       pop_en;
    logic       rd_en;
    logic       rd_valid;
    buf_addr_t  rd_addr;
    rank_t      cur_rank;
    word_t      out_word;
    logic       out_valid;
    logic       accept;

    //////////////////////////////////////////////////
    // enqueue stage
    //////////////////////////////////////////////////

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            wr_en_d     <= 1'b0;
            insert_en_d <= 1'b0;
            first_word  <= 1'b1;
        end
        else
        begin
            wr_en_d     <= s_buffer_wr_en;
            insert_en_d <= s_pifo_insert_en;
            if (wr_en_d)
                first_word <= in_word_d.last;
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        in_word_d <= '{data: s_axis_tdata, keep: s_axis_tkeep, last: s_axis_tlast};
        rank_d    <= s_axis_rank;
        if (wr_en_d && first_word)
            sop_addr <= alloc_addr;
    end

    // single word packets insert in the cycle their first word is stored
    assign start_addr   = first_word ? alloc_addr : sop_addr;
    assign insert_entry = '{rank: rank_d, addr: start_addr};

    //////////////////////////////////////////////////
    // dequeue FSM
    //////////////////////////////////////////////////

    assign pop_en = (state == IDLE) && m_axis_tready && !cal_empty;
    assign rd_en  = (state == FETCH);
    assign accept = out_valid && m_axis_tready;

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            state     <= IDLE;
            out_valid <= 1'b0;
            rd_valid  <= 1'b0;
        end
        else
        begin
            rd_valid <= rd_en;
            case (state)
                IDLE:
                    if (pop_en)
                        state <= FETCH;
                FETCH:
                    state <= PRESENT;
                PRESENT:
                begin
                    // load once the read word arrives, then hold for the port
                    if (rd_valid)
                        out_valid <= 1'b1;
                    else if (accept)
                    begin
                        out_valid <= 1'b0;
                        state     <= out_word.last ? IDLE : FETCH;
                    end
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        if (pop_en)
        begin
            rd_addr  <= top_entry.addr;
            cur_rank <= top_entry.rank;
        end
        else if (rd_en)
        begin
            // follow the packet chain
            rd_addr <= next_addr;
        end
        if (rd_valid)
            out_word <= rd_word;
    end

    //////////////////////////////////////////////////
    // submodules
    //////////////////////////////////////////////////

    free_list_manager free_list_manager_inst (
        .axis_aclk   (axis_aclk),
        .axis_resetn (axis_resetn),
        .alloc_en    (wr_en_d),
        .free_en     (rd_en),
        .free_addr   (rd_addr),
        .alloc_addr  (alloc_addr),
        .next_addr   (next_addr),
        .free_count  (buffer_free_count),
        .almost_full (buffer_almost_full)
    );

    packet_buffer packet_buffer_inst (
        .axis_aclk (axis_aclk),
        .wr_en     (wr_en_d),
        .wr_addr   (alloc_addr),
        .wr_word   (in_word_d),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_word   (rd_word)
    );

    pifo_calendar pifo_calendar_inst (
        .axis_aclk    (axis_aclk),
        .axis_resetn  (axis_resetn),
        .insert_en    (insert_en_d),
        .insert_entry (insert_entry),
        .pop_en       (pop_en),
        .top_entry    (top_entry),
        .empty        (cal_empty),
        .full         (pifo_full)
    );

    assign m_axis_tvalid = out_valid;
    assign m_axis_tdata  = out_word.data;
    assign m_axis_tkeep  = out_word.keep;
    assign m_axis_tlast  = out_word.last;
    assign m_axis_rank   = cur_rank;

    // held word under back-pressure
    assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        (out_valid && !m_axis_tready) |=> (out_valid && $stable(out_word)))
        else $error("output word changed while stalled");

    assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        s_pifo_insert_en |-> (s_buffer_wr_en && s_axis_tlast))
        else $error("insert strobe without a last word write");

endmodule

`default_nettype wire

/* hw/packet_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "oq_cfg.svh"

module packet_buffer
    import oq_pkg::*;
(
    input  wire             axis_aclk,
    input  wire             wr_en,
    input  wire buf_addr_t  wr_addr,
    input  wire word_t      wr_word,
    input  wire             rd_en,
    input  wire buf_addr_t  rd_addr,
    output word_t           rd_word
);

    localparam int DEPTH = `OQ_BUF_DEPTH;

    // data, keep and last of every stored word
    word_t mem [DEPTH];

    // write port, fed by the enqueue stage
    always_ff @(posedge axis_aclk)
    begin
        if (wr_en)
            mem[wr_addr] <= wr_word;
    end

    // registered read port
    // word stays until the next read, so it can wait for the port
    always_ff @(posedge axis_aclk)
    begin
        if (rd_en)
            rd_word <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* hw/pifo_calendar.sv */
`timescale 1ns/1ps
`default_nettype none

`include "oq_cfg.svh"

module pifo_calendar
    import oq_pkg::*;
(
    input  wire              axis_aclk,
    input  wire              axis_resetn,
    input  wire              insert_en,
    input  wire cal_entry_t  insert_entry,
    input  wire              pop_en,
    output cal_entry_t       top_entry,
    output logic             empty,
    output logic             full
);

    localparam int DEPTH = `OQ_CAL_DEPTH;

    // sorted by rank, position 0 leaves next
    cal_entry_t       q [DEPTH];
    logic [DEPTH-1:0] vld;

    // array after an optional pop
    cal_entry_t       src_q [DEPTH];
    logic [DEPTH-1:0] src_v;
    // entries that stay in front of the new one
    logic [DEPTH-1:0] src_ahead;
    // position where the new entry lands
    logic [DEPTH-1:0] slot;

    cal_entry_t       nxt_q [DEPTH];
    logic [DEPTH-1:0] nxt_v;

    //////////////////////////////////////////////////
    // pop, then insert
    //////////////////////////////////////////////////

    always_comb
    begin
        for (int i = 0; i < DEPTH - 1; i++)
        begin
            src_q[i] = pop_en ? q[i + 1] : q[i];
            src_v[i] = pop_en ? vld[i + 1] : vld[i];
        end
        src_q[DEPTH-1] = pop_en ? '0 : q[DEPTH-1];
        src_v[DEPTH-1] = !pop_en && vld[DEPTH-1];
    end

    // equal rank stays ahead, so ties leave in arrival order
    always_comb
    begin
        for (int i = 0; i < DEPTH; i++)
            src_ahead[i] = src_v[i] && (src_q[i].rank <= insert_entry.rank);
    end

    assign slot = ~src_ahead & {src_ahead[DEPTH-2:0], 1'b1};

    always_comb
    begin
        for (int i = 0; i < DEPTH; i++)
        begin
            nxt_q[i] = src_q[i];
            nxt_v[i] = src_v[i];
            if (insert_en && slot[i])
            begin
                nxt_q[i] = insert_entry;
                nxt_v[i] = 1'b1;
            end
        end
        // entries behind the new one move down by one
        for (int i = 1; i < DEPTH; i++)
        begin
            if (insert_en && !src_ahead[i] && !slot[i])
            begin
                nxt_q[i] = src_q[i - 1];
                nxt_v[i] = src_v[i - 1];
            end
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
            vld <= '0;
        else
            vld <= nxt_v;
    end

    always_ff @(posedge axis_aclk)
    begin
        q <= nxt_q;
    end

    assign top_entry = q[0];
    assign empty     = !vld[0];
    assign full      = vld[DEPTH-1];

    assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        (insert_en && full) |-> pop_en)
        else $error("calendar insert while full");

    assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        pop_en |-> !empty)
        else $error("calendar pop while empty");

endmodule

`default_nettype wire

/* verification/oq_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "oq_cfg.svh"

module oq_checker
    import oq_pkg::*;
(
    input  wire                         axis_aclk,
    input  wire                         axis_resetn,
    input  wire [`OQ_DATA_WIDTH-1:0]    s_axis_tdata,
    input  wire [`OQ_KEEP_WIDTH-1:0]    s_axis_tkeep,
    input  wire                         s_axis_tlast,
    input  wire rank_t                  s_axis_rank,
    input  wire                         s_buffer_wr_en,
    input  wire                         s_pifo_insert_en,
    input  wire                         m_axis_tready,
    input  wire                         m_axis_tvalid,
    input  wire [`OQ_DATA_WIDTH-1:0]    m_axis_tdata,
    input  wire [`OQ_KEEP_WIDTH-1:0]    m_axis_tkeep,
    input  wire                         m_axis_tlast,
    input  wire rank_t                  m_axis_rank,
    input  wire                         buffer_almost_full,
    input  wire                         pifo_full,
    input  wire buf_count_t             buffer_free_count,
    input  wire                         status_req,
    input  wire                         test_done,
    input  wire [7:0]                   test_id,
    output int                          open_packets,
    output int                          err_count,
    output int                          tests_run,
    output int                          tests_failed
);

    localparam int WORD_BITS = `OQ_DATA_WIDTH + `OQ_KEEP_WIDTH + 1;

    // every written word in arrival order
    logic [WORD_BITS-1:0] word_log [$];

    // waiting packets, a stable sort by rank
    rank_t pend_rank [$];
    int    pend_start [$];
    int    pend_len [$];

    int    pkt_start;
    int    words_out;
    bit    active;
    rank_t cur_rank;
    int    cur_start;
    int    cur_len;
    int    cur_word;
    int    err_base;
    int    words_base;
    bit    held_valid;
    logic [WORD_BITS-1:0] held_word;

    task automatic report_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        err_count++;
    endtask

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    task automatic record_input();
        int pos;
        word_log.push_back({s_axis_tdata, s_axis_tkeep, s_axis_tlast});
        if (s_pifo_insert_en)
        begin
            // new packet goes behind every packet of equal or lower rank
            pos = 0;
            while (pos < pend_rank.size() && pend_rank[pos] <= s_axis_rank)
                pos++;
            pend_rank.insert(pos, s_axis_rank);
            pend_start.insert(pos, pkt_start);
            pend_len.insert(pos, word_log.size() - pkt_start);
        end
        if (s_axis_tlast)
            pkt_start = word_log.size();
    endtask

    task automatic check_output();
        logic [WORD_BITS-1:0] got;
        logic [WORD_BITS-1:0] exp;
        got = {m_axis_tdata, m_axis_tkeep, m_axis_tlast};
        if (!active && pend_rank.size() == 0)
        begin
            report_error($sformatf("word %h sent with no packet waiting", got));
            return;
        end
        if (!active)
        begin
            cur_rank  = pend_rank.pop_front();
            cur_start = pend_start.pop_front();
            cur_len   = pend_len.pop_front();
            cur_word  = 0;
            active    = 1'b1;
        end
        exp = word_log[cur_start + cur_word];
        if (got !== exp)
            report_error($sformatf("rank %0d word %0d is %h, expected %h",
                                   cur_rank, cur_word, got, exp));
        if (m_axis_rank !== cur_rank)
            report_error($sformatf("m_axis_rank is %0d, expected %0d", m_axis_rank, cur_rank));
        cur_word++;
        words_out++;
        if (cur_word == cur_len)
            active = 1'b0;
    endtask

    task automatic check_status();
        int exp_free;
        exp_free = `OQ_BUF_DEPTH - (word_log.size() - words_out);
        if (buffer_free_count !== buf_count_t'(exp_free))
            report_error($sformatf("free count is %0d, expected %0d",
                                   buffer_free_count, exp_free));
        if (buffer_almost_full !== (exp_free <= `OQ_ALMOST_FULL_SLACK))
            report_error($sformatf("almost full is %0b with %0d free words",
                                   buffer_almost_full, exp_free));
        if (pifo_full !== (pend_rank.size() >= `OQ_CAL_DEPTH))
            report_error($sformatf("pifo full is %0b with %0d packets stored",
                                   pifo_full, pend_rank.size()));
        if (m_axis_tvalid !== 1'b0)
            report_error("tvalid high with nothing to send");
    endtask

    task automatic close_test();
        if (active || pend_rank.size() != 0)
            report_error($sformatf("%0d packets never left the queue",
                                   pend_rank.size() + int'(active)));
        tests_run++;
        if (err_count == err_base)
            $display("test %0d: ok, %0d words checked", test_id, words_out - words_base);
        else
        begin
            tests_failed++;
            $display("test %0d: failed with %0d errors", test_id, err_count - err_base);
        end
        err_base   = err_count;
        words_base = words_out;
    endtask

    //////////////////////////////////////////////////
    // sampling
    //////////////////////////////////////////////////

    always @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            word_log.delete();
            pend_rank.delete();
            pend_start.delete();
            pend_len.delete();
            pkt_start    = 0;
            words_out    = 0;
            active       = 1'b0;
            err_count    = 0;
            err_base     = 0;
            words_base   = 0;
            tests_run    = 0;
            tests_failed = 0;
            held_valid   = 1'b0;
        end
        else
        begin
            // stalled word must stay on the port
            if (held_valid && !(m_axis_tvalid &&
                {m_axis_tdata, m_axis_tkeep, m_axis_tlast} === held_word))
                report_error("output word changed under back-pressure");
            held_valid = m_axis_tvalid && !m_axis_tready;
            held_word  = {m_axis_tdata, m_axis_tkeep, m_axis_tlast};

            if (s_buffer_wr_en)
                record_input();
            if (m_axis_tvalid && m_axis_tready)
                check_output();
            if (status_req)
                check_status();
            if (test_done)
                close_test();
        end
        open_packets = pend_rank.size() + int'(active);
    end

endmodule

`default_nettype wire

/* verification/oq_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "oq_cfg.svh"

module oq_tb
    import oq_pkg::*;
();

    localparam int NUM_TESTS     = 5;
    localparam int ROOM_TIMEOUT  = 500;
    localparam int DRAIN_TIMEOUT = 5000;

    logic                        axis_aclk;
    logic                        axis_resetn;
    logic [`OQ_DATA_WIDTH-1:0]   s_axis_tdata;
    logic [`OQ_KEEP_WIDTH-1:0]   s_axis_tkeep;
    logic                        s_axis_tlast;
    rank_t                       s_axis_rank;
    logic                        s_buffer_wr_en;
    logic                        s_pifo_insert_en;
    logic                        m_axis_tready;
    logic                        m_axis_tvalid;
    logic [`OQ_DATA_WIDTH-1:0]   m_axis_tdata;
    logic [`OQ_KEEP_WIDTH-1:0]   m_axis_tkeep;
    logic                        m_axis_tlast;
    rank_t                       m_axis_rank;
    logic                        buffer_almost_full;
    logic                        pifo_full;
    buf_count_t                  buffer_free_count;

    logic                        status_req;
    logic                        test_done;
    logic [7:0]                  test_id;
    int                          open_packets;
    int                          err_count;
    int                          tests_run;
    int                          tests_failed;

    // packet 0 sits in the low byte of ranks and the low nibble of lengths
    int          tbl_npkt   [NUM_TESTS];
    bit          tbl_random [NUM_TESTS];
    logic [63:0] tbl_ranks  [NUM_TESTS];
    logic [31:0] tbl_lens   [NUM_TESTS];

    logic [31:0] rnd_state;
    bit          random_ready;
    bit          ready_level;
    bit          timed_out;

    output_queue output_queue_inst (
        .axis_aclk          (axis_aclk),
        .axis_resetn        (axis_resetn),
        .s_axis_tdata       (s_axis_tdata),
        .s_axis_tkeep       (s_axis_tkeep),
        .s_axis_tlast       (s_axis_tlast),
        .s_axis_rank        (s_axis_rank),
        .s_buffer_wr_en     (s_buffer_wr_en),
        .s_pifo_insert_en   (s_pifo_insert_en),
        .m_axis_tready      (m_axis_tready),
        .m_axis_tvalid      (m_axis_tvalid),
        .m_axis_tdata       (m_axis_tdata),
        .m_axis_tkeep       (m_axis_tkeep),
        .m_axis_tlast       (m_axis_tlast),
        .m_axis_rank        (m_axis_rank),
        .buffer_almost_full (buffer_almost_full),
        .pifo_full          (pifo_full),
        .buffer_free_count  (buffer_free_count)
    );

    oq_checker oq_checker_inst (
        .axis_aclk          (axis_aclk),
        .axis_resetn        (axis_resetn),
        .s_axis_tdata       (s_axis_tdata),
        .s_axis_tkeep       (s_axis_tkeep),
        .s_axis_tlast       (s_axis_tlast),
        .s_axis_rank        (s_axis_rank),
        .s_buffer_wr_en     (s_buffer_wr_en),
        .s_pifo_insert_en   (s_pifo_insert_en),
        .m_axis_tready      (m_axis_tready),
        .m_axis_tvalid      (m_axis_tvalid),
        .m_axis_tdata       (m_axis_tdata),
        .m_axis_tkeep       (m_axis_tkeep),
        .m_axis_tlast       (m_axis_tlast),
        .m_axis_rank        (m_axis_rank),
        .buffer_almost_full (buffer_almost_full),
        .pifo_full          (pifo_full),
        .buffer_free_count  (buffer_free_count),
        .status_req         (status_req),
        .test_done          (test_done),
        .test_id            (test_id),
        .open_packets       (open_packets),
        .err_count          (err_count),
        .tests_run          (tests_run),
        .tests_failed       (tests_failed)
    );

    initial
    begin
        axis_aclk = 1'b0;
        forever #10 axis_aclk = ~axis_aclk;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic load_table();
        // one packet of five words
        tbl_npkt[0]   = 1;
        tbl_random[0] = 1'b0;
        tbl_ranks[0]  = 64'h03;
        tbl_lens[0]   = 32'h5;
        // distinct ranks 40 10 30 20
        tbl_npkt[1]   = 4;
        tbl_random[1] = 1'b0;
        tbl_ranks[1]  = 64'h141E0A28;
        tbl_lens[1]   = 32'h1423;
        // ties 7 7 2 7 2
        tbl_npkt[2]   = 5;
        tbl_random[2] = 1'b0;
        tbl_ranks[2]  = 64'h0207020707;
        tbl_lens[2]   = 32'h24132;
        // random tready, ranks never fall so order is arrival order
        tbl_npkt[3]   = 6;
        tbl_random[3] = 1'b1;
        tbl_ranks[3]  = 64'h090904040101;
        tbl_lens[3]   = 32'h253614;
        // fills the calendar and the almost full margin
        tbl_npkt[4]   = 8;
        tbl_random[4] = 1'b0;
        tbl_ranks[4]  = 64'h0102030405060708;
        tbl_lens[4]   = 32'h77777777;
    endtask

    // inputs move 2 ns after the edge
    task automatic tick();
        @(posedge axis_aclk);
        #2;
        if (random_ready)
        begin
            rnd_state     = lcg_next(rnd_state);
            m_axis_tready = rnd_state[20];
        end
        else
            m_axis_tready = ready_level;
    endtask

    task automatic request_status();
        status_req = 1'b1;
        tick();
        status_req = 1'b0;
    endtask

    task automatic send_packet(input rank_t rank, input int len);
        int n;
        n = 0;
        while ((buffer_almost_full || pifo_full) && n < ROOM_TIMEOUT)
        begin
            tick();
            n++;
        end
        if (buffer_almost_full || pifo_full)
        begin
            $display("timeout: no room in the buffer or calendar for a new packet");
            timed_out = 1'b1;
            return;
        end
        for (int w = 0; w < len; w++)
        begin
            rnd_state        = lcg_next(rnd_state);
            s_axis_tdata     = rnd_state;
            s_axis_tkeep     = (w == len - 1) ? (rnd_state[31:28] | 4'h1) : 4'hF;
            s_axis_tlast     = (w == len - 1);
            s_axis_rank      = rank;
            s_buffer_wr_en   = 1'b1;
            s_pifo_insert_en = (w == len - 1);
            tick();
        end
        s_buffer_wr_en   = 1'b0;
        s_pifo_insert_en = 1'b0;
        s_axis_tlast     = 1'b0;
        // word and calendar entry land two cycles after the strobe
        repeat (3) tick();
    endtask

    task automatic run_test(input int t);
        int n;
        random_ready = tbl_random[t];
        ready_level  = 1'b0;
        tick();
        for (int p = 0; p < tbl_npkt[t]; p++)
        begin
            send_packet(tbl_ranks[t][8*p +: 8], tbl_lens[t][4*p +: 4]);
            if (timed_out)
                return;
        end
        if (!random_ready)
            request_status();

        ready_level = 1'b1;
        n = 0;
        while (open_packets != 0 && n < DRAIN_TIMEOUT)
        begin
            tick();
            n++;
        end
        if (open_packets != 0)
        begin
            $display("timeout: test %0d still has %0d packets queued", t, open_packets);
            timed_out = 1'b1;
            return;
        end
        random_ready = 1'b0;
        repeat (2) tick();
        request_status();
        test_id   = 8'(t);
        test_done = 1'b1;
        tick();
        test_done = 1'b0;
    endtask

    task automatic finish_run();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
        if (!timed_out && err_count == 0 && tests_failed == 0 && tests_run == NUM_TESTS)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial
    begin
        load_table();
        rnd_state        = 32'd10819;
        random_ready     = 1'b0;
        ready_level      = 1'b0;
        timed_out        = 1'b0;
        axis_resetn      = 1'b0;
        s_axis_tdata     = '0;
        s_axis_tkeep     = '0;
        s_axis_tlast     = 1'b0;
        s_axis_rank      = '0;
        s_buffer_wr_en   = 1'b0;
        s_pifo_insert_en = 1'b0;
        m_axis_tready    = 1'b0;
        status_req       = 1'b0;
        test_done        = 1'b0;
        test_id          = '0;

        repeat (10) @(posedge axis_aclk);
        #2;
        axis_resetn = 1'b1;
        tick();
        // idle status straight after reset
        request_status();

        for (int t = 0; t < NUM_TESTS; t++)
        begin
            if (!timed_out)
                run_test(t);
        end
        tick();
        finish_run();
    end

endmodule

`default_nettype wire
